//--- rtl/fpAddPkg.sv
// Float adder shared definitions
package fpAddPkg;

    localparam int FLOAT_WIDTH = 32;
    localparam int EXP_WIDTH = 8;
    localparam int MANT_WIDTH = 23;
    localparam int SIG_WIDTH = 32;                          // hidden bit, mantissa, guard bits.
    localparam int GUARD_WIDTH = SIG_WIDTH - MANT_WIDTH - 1;
    localparam int LZC_WIDTH = $clog2(SIG_WIDTH + 1);
    localparam int BUFFER_DEPTH = 4;
    localparam int OUT_CREDIT_MAX = 4;
    localparam int PTR_WIDTH = $clog2(BUFFER_DEPTH);
    localparam int COUNT_WIDTH = $clog2(BUFFER_DEPTH + 1);
    localparam int CREDIT_WIDTH = $clog2(OUT_CREDIT_MAX + 1);

    localparam logic [EXP_WIDTH-1:0] EXP_MAX = '1;
    localparam logic [FLOAT_WIDTH-1:0] CANON_NAN = 32'h7FFF_FFFF;

    typedef enum logic {opAdd, opSub} opCodeT;

    typedef enum logic [2:0] {classZero, classSub, classNorm, classInf, classNan} fpClassT;

    function automatic logic fpSign(input logic [FLOAT_WIDTH-1:0] word);
        return word[FLOAT_WIDTH-1];
    endfunction

    function automatic logic [EXP_WIDTH-1:0] fpExp(input logic [FLOAT_WIDTH-1:0] word);
        return word[FLOAT_WIDTH-2 -: EXP_WIDTH];
    endfunction

    function automatic logic [MANT_WIDTH-1:0] fpMant(input logic [FLOAT_WIDTH-1:0] word);
        return word[MANT_WIDTH-1:0];
    endfunction

endpackage

//--- rtl/fpUnpack.sv
// Unpack and classify stage
module fpUnpack
(
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              inValid,
    input  logic [fpAddPkg::FLOAT_WIDTH-1:0]  opA,
    input  logic [fpAddPkg::FLOAT_WIDTH-1:0]  opB,
    input  fpAddPkg::opCodeT                  opCode,
    output logic                              unpValid,
    output logic [fpAddPkg::FLOAT_WIDTH-1:0]  unpA,
    output logic [fpAddPkg::FLOAT_WIDTH-1:0]  unpB,
    output fpAddPkg::fpClassT                 unpClassA,
    output fpAddPkg::fpClassT                 unpClassB,
    output logic [fpAddPkg::EXP_WIDTH-1:0]    bigExp,
    output logic [fpAddPkg::SIG_WIDTH-1:0]    bigSig,
    output logic [fpAddPkg::SIG_WIDTH-1:0]    smallSig,
    output logic [fpAddPkg::EXP_WIDTH-1:0]    expDiff,
    output logic                              bigSign,
    output logic                              smallSign,
    output logic                              bypassAlu,
    output logic                              bigIsA
);
    import fpAddPkg::*;

    logic [FLOAT_WIDTH-1:0] effB;
    logic [EXP_WIDTH-1:0]   expA;
    logic [EXP_WIDTH-1:0]   expB;
    logic [SIG_WIDTH-1:0]   sigA;
    logic [SIG_WIDTH-1:0]   sigB;
    logic [EXP_WIDTH-1:0]   diff;
    logic                   aBigger;

    function automatic fpClassT classify(input logic [FLOAT_WIDTH-1:0] word);
        if (fpExp(word) == '0)
            return (fpMant(word) == '0) ? classZero : classSub;
        if (fpExp(word) == EXP_MAX)
            return (fpMant(word) == '0) ? classInf : classNan;
        return classNorm;
    endfunction

    always_comb
    begin
        effB = {(opCode == opAdd) ? fpSign(opB) : ~fpSign(opB), opB[FLOAT_WIDTH-2:0]}; // b - x is b + (-x).
        expA = (fpExp(opA) == '0) ? EXP_WIDTH'(1) : fpExp(opA);           // subnormals scale as exponent 1.
        expB = (fpExp(effB) == '0) ? EXP_WIDTH'(1) : fpExp(effB);
        sigA = {fpExp(opA) != '0, fpMant(opA), {GUARD_WIDTH{1'b0}}};
        sigB = {fpExp(effB) != '0, fpMant(effB), {GUARD_WIDTH{1'b0}}};
        aBigger = opA[FLOAT_WIDTH-2:0] >= effB[FLOAT_WIDTH-2:0];       // raw field order is magnitude order.
        diff = aBigger ? expA - expB : expB - expA;
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            unpValid <= 1'b0;
        else
            unpValid <= inValid;
    end

    always_ff @(posedge clk)
    begin
        if (inValid)
        begin
            unpA      <= opA;
            unpB      <= effB;
            unpClassA <= classify(opA);
            unpClassB <= classify(effB);
            bigExp    <= aBigger ? expA : expB;
            bigSig    <= aBigger ? sigA : sigB;
            smallSig  <= aBigger ? sigB : sigA;
            expDiff   <= diff;
            bigSign   <= aBigger ? fpSign(opA) : fpSign(effB);
            smallSign <= aBigger ? fpSign(effB) : fpSign(opA);
            bypassAlu <= diff > EXP_WIDTH'(SIG_WIDTH);      // small operand sits below every guard bit.
            bigIsA    <= aBigger;
        end
    end

endmodule

//--- rtl/fpAlignAdd.sv
// Align and add stage
module fpAlignAdd
(
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              unpValid,
    input  logic [fpAddPkg::FLOAT_WIDTH-1:0]  unpA,
    input  logic [fpAddPkg::FLOAT_WIDTH-1:0]  unpB,
    input  fpAddPkg::fpClassT                 unpClassA,
    input  fpAddPkg::fpClassT                 unpClassB,
    input  logic [fpAddPkg::EXP_WIDTH-1:0]    bigExp,
    input  logic [fpAddPkg::SIG_WIDTH-1:0]    bigSig,
    input  logic [fpAddPkg::SIG_WIDTH-1:0]    smallSig,
    input  logic [fpAddPkg::EXP_WIDTH-1:0]    expDiff,
    input  logic                              bigSign,
    input  logic                              smallSign,
    input  logic                              bypassAlu,
    input  logic                              bigIsA,
    output logic                              algValid,
    output logic [fpAddPkg::SIG_WIDTH-1:0]    alignedResult,
    output logic                              carryOut,
    output logic                              sticky,
    output logic [fpAddPkg::EXP_WIDTH-1:0]    exponentOut,
    output logic                              alignedSign,
    output logic [fpAddPkg::FLOAT_WIDTH-1:0]  algA,
    output logic [fpAddPkg::FLOAT_WIDTH-1:0]  algB,
    output fpAddPkg::fpClassT                 algClassA,
    output fpAddPkg::fpClassT                 algClassB,
    output logic                              algBypassAlu,
    output logic                              algBigIsA
);
    import fpAddPkg::*;

    logic [SIG_WIDTH-1:0] shiftedSig;
    logic [SIG_WIDTH-1:0] sumSig;
    logic                 sumCarry;
    logic                 lostBits;
    logic                 sumSign;

    always_comb
    begin
        shiftedSig = smallSig >> expDiff;
        lostBits = |(smallSig & ~({SIG_WIDTH{1'b1}} << expDiff));
        if (bigSign == smallSign)
        begin
            {sumCarry, sumSig} = {1'b0, bigSig} + {1'b0, shiftedSig};
            sumSign = bigSign;
        end
        else
        begin
            // borrow one unit so the sticky fraction stays a positive remainder.
            sumSig = bigSig - shiftedSig - SIG_WIDTH'(lostBits);
            sumCarry = 1'b0;
            sumSign = (sumSig == '0 && !lostBits) ? 1'b0 : bigSign;   // exact cancellation is +0.
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            algValid <= 1'b0;
        else
            algValid <= unpValid;
    end

    always_ff @(posedge clk)
    begin
        if (unpValid)
        begin
            alignedResult <= sumSig;
            carryOut      <= sumCarry;
            sticky        <= lostBits;
            exponentOut   <= bigExp;
            alignedSign   <= sumSign;
            algA          <= unpA;
            algB          <= unpB;
            algClassA     <= unpClassA;
            algClassB     <= unpClassB;
            algBypassAlu  <= bypassAlu;
            algBigIsA     <= bigIsA;
        end
    end

    // the larger significand must cover the aligned smaller one, or the difference wraps.
    assert property (@(posedge clk) disable iff (!arstN)
        (unpValid && bigSign != smallSign)
            |-> ({1'b0, bigSig} >= {1'b0, shiftedSig} + (SIG_WIDTH + 1)'(lostBits)))
        else $error("operand magnitude order lost between stages");

endmodule

//--- rtl/fpNormalize.sv
// Normalize and round stage
module fpNormalize
(
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              algValid,
    input  logic [fpAddPkg::SIG_WIDTH-1:0]    alignedResult,
    input  logic                              carryOut,
    input  logic                              sticky,
    input  logic [fpAddPkg::EXP_WIDTH-1:0]    exponentOut,
    input  logic                              alignedSign,
    input  logic [fpAddPkg::FLOAT_WIDTH-1:0]  algA,
    input  logic [fpAddPkg::FLOAT_WIDTH-1:0]  algB,
    input  fpAddPkg::fpClassT                 algClassA,
    input  fpAddPkg::fpClassT                 algClassB,
    input  logic                              algBypassAlu,
    input  logic                              algBigIsA,
    output logic                              normValid,
    output logic [fpAddPkg::FLOAT_WIDTH-1:0]  normResult
);
    import fpAddPkg::*;

    logic [LZC_WIDTH-1:0]             leadZeros;
    logic [EXP_WIDTH-1:0]             shiftAmount;
    logic [EXP_WIDTH-1:0]             normExp;
    logic [SIG_WIDTH-1:0]             shiftedSig;
    logic [MANT_WIDTH-1:0]            keptMant;
    logic                             guard;
    logic                             roundBit;
    logic                             stickyAll;
    logic                             roundUp;
    logic [EXP_WIDTH+MANT_WIDTH:0]    roundedWord;
    logic [FLOAT_WIDTH-1:0]           arithResult;
    logic [FLOAT_WIDTH-1:0]           nextResult;

    function automatic logic [LZC_WIDTH-1:0] countLeadingZeros(input logic [SIG_WIDTH-1:0] value);
        logic [LZC_WIDTH-1:0] count;
        logic                 found;
        count = LZC_WIDTH'(SIG_WIDTH);
        found = 1'b0;
        for (int i = SIG_WIDTH - 1; i >= 0; i--)
        begin
            if (value[i] && !found)
            begin
                count = LZC_WIDTH'(SIG_WIDTH - 1 - i);
                found = 1'b1;
            end
        end
        return count;
    endfunction

    always_comb
    begin
        leadZeros = countLeadingZeros(alignedResult);
        shiftAmount = '0;
        shiftedSig = alignedResult;
        normExp = exponentOut + EXP_WIDTH'(1);
        if (carryOut)
        begin
            keptMant = alignedResult[SIG_WIDTH-1 -: MANT_WIDTH];     // the carry is the hidden bit.
            guard = alignedResult[GUARD_WIDTH];
            roundBit = alignedResult[GUARD_WIDTH-1];
            stickyAll = sticky | (|alignedResult[GUARD_WIDTH-2:0]);
        end
        else
        begin
            if (EXP_WIDTH'(leadZeros) < exponentOut)
            begin
                shiftAmount = EXP_WIDTH'(leadZeros);
                normExp = exponentOut - shiftAmount;
            end
            else
            begin
                shiftAmount = exponentOut - EXP_WIDTH'(1);           // stop at the subnormal scale.
                normExp = '0;
            end
            shiftedSig = alignedResult << shiftAmount;
            keptMant = shiftedSig[SIG_WIDTH-2 -: MANT_WIDTH];
            guard = shiftedSig[GUARD_WIDTH-1];
            roundBit = shiftedSig[GUARD_WIDTH-2];
            stickyAll = sticky | (|shiftedSig[GUARD_WIDTH-3:0]);
        end
        roundUp = guard & (roundBit | stickyAll | keptMant[0]);
        // a mantissa carry ripples straight into the exponent field.
        roundedWord = {1'b0, normExp, keptMant} + (EXP_WIDTH + MANT_WIDTH + 1)'(roundUp);
        if (roundedWord[EXP_WIDTH+MANT_WIDTH -: EXP_WIDTH+1] >= {1'b0, EXP_MAX})
            arithResult = {alignedSign, EXP_MAX, {MANT_WIDTH{1'b0}}};
        else
            arithResult = {alignedSign, roundedWord[EXP_WIDTH+MANT_WIDTH-1:0]};
    end

    always_comb
    begin
        if (algClassA == classNan)
            nextResult = algA;
        else if (algClassB == classNan)
            nextResult = algB;
        else if (algClassA == classInf)
            nextResult = (algClassB == classInf && fpSign(algA) != fpSign(algB)) ? CANON_NAN : algA;
        else if (algClassB == classInf)
            nextResult = algB;
        else if (algClassB == classZero)
            nextResult = algA;                                    // also zero plus zero.
        else if (algClassA == classZero)
            nextResult = algB;
        else if (algClassA == classSub && algClassB == classSub)
            nextResult = {alignedSign, {(EXP_WIDTH - 1){1'b0}}, alignedResult[SIG_WIDTH-1],
                          alignedResult[SIG_WIDTH-2 -: MANT_WIDTH]};
        else if (algBypassAlu)
            nextResult = algBigIsA ? algA : algB;
        else if (!carryOut && alignedResult == '0)
            nextResult = '0;                                      // exact cancellation is +0.
        else
            nextResult = arithResult;
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            normValid <= 1'b0;
        else
            normValid <= algValid;
    end

    always_ff @(posedge clk)
    begin
        if (algValid)
            normResult <= nextResult;
    end

endmodule

//--- rtl/resultBuffer.sv
// Result FIFO with credits
module resultBuffer
(
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              normValid,
    input  logic [fpAddPkg::FLOAT_WIDTH-1:0]  normResult,
    input  logic                              outCreditGrant,
    output logic                              resultValid,
    output logic [fpAddPkg::FLOAT_WIDTH-1:0]  result,
    output logic                              inCredit
);
    import fpAddPkg::*;

    logic [FLOAT_WIDTH-1:0]  entries [BUFFER_DEPTH];
    logic [PTR_WIDTH-1:0]    wrPtr;
    logic [PTR_WIDTH-1:0]    rdPtr;
    logic [COUNT_WIDTH-1:0]  fillCount;
    logic [CREDIT_WIDTH-1:0] outCredits;
    logic                    sendNow;

    assign sendNow = (outCredits != '0) && (fillCount != '0);   // needs both a credit and an entry.
    assign resultValid = sendNow;
    assign result = entries[rdPtr];

    always_ff @(posedge clk)
    begin
        if (normValid)
            entries[wrPtr] <= normResult;
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            fillCount  <= '0;
            outCredits <= '0;
            inCredit   <= 1'b0;
        end
        else
        begin
            if (normValid)
                wrPtr <= wrPtr + PTR_WIDTH'(1);
            if (sendNow)
                rdPtr <= rdPtr + PTR_WIDTH'(1);
            fillCount  <= fillCount + COUNT_WIDTH'(normValid) - COUNT_WIDTH'(sendNow);
            outCredits <= outCredits + CREDIT_WIDTH'(outCreditGrant) - CREDIT_WIDTH'(sendNow);
            inCredit   <= sendNow;                            // the freed slot goes back to the source.
        end
    end

    // the source only sends against slots it owns, so the pipeline never overfills the FIFO.
    assert property (@(posedge clk) disable iff (!arstN)
        normValid |-> (fillCount != COUNT_WIDTH'(BUFFER_DEPTH)))
        else $error("result FIFO written while full");

    assert property (@(posedge clk) disable iff (!arstN)
        outCredits <= CREDIT_WIDTH'(OUT_CREDIT_MAX))
        else $error("consumer granted more output credits than allowed");

endmodule

//--- rtl/fpAddTop.sv
// Pipelined float adder top
module fpAddTop
(
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              inValid,
    input  logic [fpAddPkg::FLOAT_WIDTH-1:0]  opA,
    input  logic [fpAddPkg::FLOAT_WIDTH-1:0]  opB,
    input  fpAddPkg::opCodeT                  opCode,
    input  logic                              outCreditGrant,
    output logic                              inCredit,
    output logic                              resultValid,
    output logic [fpAddPkg::FLOAT_WIDTH-1:0]  result
);
    import fpAddPkg::*;

    // stage 1 to stage 2.
    logic                   unpValid;
    logic [FLOAT_WIDTH-1:0] unpA;
    logic [FLOAT_WIDTH-1:0] unpB;
    fpClassT                unpClassA;
    fpClassT                unpClassB;
    logic [EXP_WIDTH-1:0]   bigExp;
    logic [SIG_WIDTH-1:0]   bigSig;
    logic [SIG_WIDTH-1:0]   smallSig;
    logic [EXP_WIDTH-1:0]   expDiff;
    logic                   bigSign;
    logic                   smallSign;
    logic                   bypassAlu;
    logic                   bigIsA;

    // stage 2 to stage 3.
    logic                   algValid;
    logic [SIG_WIDTH-1:0]   alignedResult;
    logic                   carryOut;
    logic                   sticky;
    logic [EXP_WIDTH-1:0]   exponentOut;
    logic                   alignedSign;
    logic [FLOAT_WIDTH-1:0] algA;
    logic [FLOAT_WIDTH-1:0] algB;
    fpClassT                algClassA;
    fpClassT                algClassB;
    logic                   algBypassAlu;
    logic                   algBigIsA;

    // stage 3 to the FIFO.
    logic                   normValid;
    logic [FLOAT_WIDTH-1:0] normResult;

    fpUnpack fpUnpack_inst (.*);

    fpAlignAdd fpAlignAdd_inst (.*);

    fpNormalize fpNormalize_inst (.*);

    resultBuffer resultBuffer_inst (.*);

endmodule

//--- tests/fpAddTopTb.sv
// Float adder testbench
module fpAddTopTb;
    import fpAddPkg::*;

    localparam int NUM_RANDOM = 200;
    localparam int STALL_CYCLES = 30;
    localparam int WIDE = 288;                              // room for any exponent gap.

    logic        clk;
    logic        arstN;
    logic        inValid;
    logic [31:0] opA;
    logic [31:0] opB;
    opCodeT      opCode;
    logic        outCreditGrant;
    logic        inCredit;
    logic        resultValid;
    logic [31:0] result;

    logic [31:0] opAQ[$];
    logic [31:0] opBQ[$];
    opCodeT      opQ[$];
    logic [31:0] expected[$];
    int          totalOps;
    logic        sourceDone = 1'b0;
    int          cycles = 0;
    int          timeoutLimit;

    fpAddTop fpAddTop_inst (.*);

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [WIDE-1:0] wideSig(input logic [31:0] word);
        return {{(WIDE - 24){1'b0}}, word[30:23] != 8'h00, word[22:0]};
    endfunction

    // B is taken after the opcode has set its sign.
    function automatic logic [31:0] refFpAdd(input logic [31:0] a, input logic [31:0] b,
                                             input opCodeT op);
        logic [31:0]     bEff;
        logic [WIDE-1:0] mag;
        logic [WIDE-1:0] magA;
        logic [WIDE-1:0] magB;
        logic [WIDE-1:0] rem;
        logic [WIDE-1:0] half;
        logic [39:0]     word;
        logic            sign;
        int              eA;
        int              eB;
        int              eMin;
        int              eQ;
        int              msb;
        int              shift;
        bEff = {b[31] ^ (op == opSub), b[30:0]};
        if (a[30:23] == 8'hFF && a[22:0] != 0)
            return a;
        if (bEff[30:23] == 8'hFF && bEff[22:0] != 0)
            return bEff;
        if (a[30:0] == 31'h7F800000)
            return (bEff[30:0] == 31'h7F800000 && a[31] != bEff[31]) ? 32'h7FFFFFFF : a;
        if (bEff[30:0] == 31'h7F800000)
            return bEff;
        if (bEff[30:0] == 0)
            return a;
        if (a[30:0] == 0)
            return bEff;
        eA = (a[30:23] == 0) ? 1 : int'(a[30:23]);
        eB = (bEff[30:23] == 0) ? 1 : int'(bEff[30:23]);
        eMin = (eA < eB) ? eA : eB;
        magA = wideSig(a) << (eA - eMin);
        magB = wideSig(bEff) << (eB - eMin);
        if (a[31] == bEff[31])
        begin
            mag = magA + magB;
            sign = a[31];
        end
        else if (magA >= magB)
        begin
            mag = magA - magB;
            sign = a[31];
        end
        else
        begin
            mag = magB - magA;
            sign = bEff[31];
        end
        if (mag == 0)
            return 32'h0;
        msb = 0;
        for (int i = 0; i < WIDE; i++)
            if (mag[i])
                msb = i;
        eQ = msb + eMin - 23;
        if (eQ < 1)
            eQ = 1;                                         // subnormals share the scale of exponent 1.
        shift = eQ - eMin;
        if (shift <= 0)
            mag = mag << (-shift);
        else
        begin
            rem = mag & ((WIDE'(1) << shift) - 1);
            half = WIDE'(1) << (shift - 1);
            mag = mag >> shift;
            if (rem > half || (rem == half && mag[0]))
                mag = mag + 1;
        end
        word = (40'(eQ - 1) << 23) + mag[39:0];             // the hidden bit lands in the exponent.
        if (word[39:23] >= 17'd255)
            return {sign, 8'hFF, 23'h0};
        return {sign, word[30:0]};
    endfunction

    task automatic queueOp(input logic [31:0] a, input logic [31:0] b, input opCodeT op);
        opAQ.push_back(a);
        opBQ.push_back(b);
        opQ.push_back(op);
    endtask

    task automatic makeRandomOp();
        logic [31:0] a;
        logic [31:0] b;
        logic [7:0]  expA;
        a = $urandom;
        b = $urandom;
        expA = 8'($urandom_range(20, 240));
        a[30:23] = expA;
        if ($urandom_range(0, 3) == 0)
            b[30:23] = 8'($urandom_range(1, 254));
        else
            b[30:23] = expA - 8'($urandom_range(0, 12));    // close exponents cancel deeply.
        if (b[30:0] == a[30:0])
            b[0] = ~b[0];
        if ($urandom_range(0, 1) == 1)
            queueOp(b, a, ($urandom_range(0, 1) == 1) ? opSub : opAdd);
        else
            queueOp(a, b, ($urandom_range(0, 1) == 1) ? opSub : opAdd);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= timeoutLimit)
            reportFailure("timeout: not every result came back within the cycle limit");
    end

    initial
    begin
        void'($urandom(67));
        arstN = 1'b0;
        inValid = 1'b0;
        opA = '0;
        opB = '0;
        opCode = opAdd;
        outCreditGrant = 1'b0;
        queueOp(32'h7FC00001, 32'h3F800000, opAdd);
        queueOp(32'h3F800000, 32'hFF812345, opSub);
        queueOp(32'h7F800000, 32'h7F800000, opSub);
        queueOp(32'hFF800000, 32'h42280000, opAdd);
        queueOp(32'h3F800000, 32'h7F800000, opSub);
        queueOp(32'h00000000, 32'h40490FDB, opAdd);
        queueOp(32'h80000000, 32'h00000000, opAdd);
        queueOp(32'h0F912345, 32'h0F912345, opSub);
        queueOp(32'hC2F60000, 32'hC2F60000, opSub);     // cancels far above the guard bits.
        queueOp(32'h00400000, 32'h00400000, opAdd);     // carries into exponent 1.
        queueOp(32'h00012345, 32'h00054321, opSub);
        queueOp(32'h7F7FFFFF, 32'h7F7FFFFF, opAdd);
        queueOp(32'hFF7FFFFF, 32'h7F7FFFFF, opSub);
        queueOp(32'h3F800000, 32'h2E800000, opSub);
        queueOp(32'h3F800000, 32'h2F800000, opAdd);
        queueOp(32'h3F800000, 32'h33800000, opAdd);     // a tie that stays even.
        queueOp(32'h3F800001, 32'h33800000, opAdd);
        repeat (NUM_RANDOM) makeRandomOp();
        totalOps = opAQ.size();
        timeoutLimit = 20 * totalOps + 200;
        repeat (2)
        begin
            @(posedge clk);
            assert (!resultValid && !inCredit)
                else reportFailure("resultValid or inCredit went high during reset");
        end
        arstN <= 1'b1;
        wait (sourceDone);
        repeat (10) @(posedge clk);
        if (expected.size() == 0)
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
        else
            reportFailure("operations were still waiting for a result at the end of the run");
    end

    initial
    begin : source
        int credits;
        int idx;
        credits = BUFFER_DEPTH;
        idx = 0;
        wait (arstN);
        while (idx < totalOps || credits < BUFFER_DEPTH)
        begin
            @(posedge clk);
            if (inCredit)
                credits++;
            assert (credits <= BUFFER_DEPTH)
                else reportFailure("more input credits came back than there are buffer slots");
            if (idx < totalOps && credits > 0 && $urandom_range(0, 3) != 0)
            begin
                inValid <= 1'b1;
                opA <= opAQ[idx];
                opB <= opBQ[idx];
                opCode <= opQ[idx];
                expected.push_back(refFpAdd(opAQ[idx], opBQ[idx], opQ[idx]));
                credits--;
                idx++;
            end
            else
                inValid <= 1'b0;
        end
        sourceDone = 1'b1;                                  // every credit is back home.
    end

    initial
    begin : consumer
        int          held;
        int          sinceReset;
        logic [31:0] want;
        held = 0;
        sinceReset = 0;
        wait (arstN);
        forever
        begin
            @(posedge clk);
            sinceReset++;
            if (resultValid)
            begin
                assert (held > 0)
                    else reportFailure("a result was sent without an output credit");
                held--;
                assert (expected.size() > 0)
                    else reportFailure("a result arrived with no operation outstanding");
                want = expected.pop_front();
                assert (result === want)
                    else reportFailure($sformatf("[ERROR] result = 0x%08h, expected 0x%08h",
                                                 result, want));
            end
            if (outCreditGrant)
                held++;                                     // mirrors the output credit counter.
            if (sinceReset <= STALL_CYCLES)
            begin
                assert (!resultValid && !inCredit)
                    else reportFailure("output appeared before any output credit was granted");
                if (sinceReset == STALL_CYCLES)
                    assert (expected.size() == BUFFER_DEPTH)
                        else reportFailure("source was not held at the buffer depth while stalled");
                outCreditGrant <= 1'b0;
            end
            else
                outCreditGrant <= (held < OUT_CREDIT_MAX) && (sinceReset % 80 >= 20)
                                  && ($urandom_range(0, 2) != 0);
        end
    end

endmodule

//--- fpAddTop.f
rtl/fpAddPkg.sv
rtl/fpUnpack.sv
rtl/fpAlignAdd.sv
rtl/fpNormalize.sv
rtl/resultBuffer.sv
rtl/fpAddTop.sv
tests/fpAddTopTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Builds the float adder testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fpAddTopTb -f fpAddTop.f -o fpAddTopSim
./obj_dir/fpAddTopSim 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi
echo "simulation finished cleanly"
